//--- Bender.yml
package:
  name: bpred

sources:
  - include_dirs:
      - include
    files:
      - verilog/bpred_pkg.sv
      - verilog/bpClassDecode.sv
      - verilog/bpDirTable.sv
      - verilog/bpBtb.sv
      - verilog/bpRas.sv
      - verilog/bpResolve.sv
      - verilog/bpred.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/bpredTb.sv

//--- dv/bpredTb.sv
/*
  Branch predictor testbench
  Drives fetch, decode and execute as a five-stage pipeline would and
  checks predictions, corrections and the memory report against a model
*/
`include "bpred_defines.svh"

module bpredTb;
  timeunit 1ns;
  timeprecision 100ps;
  import bpred_pkg::*;

  localparam int DirEntries = 2 ** `BP_DIR_BITS;
  localparam int BtbEntries = 2 ** `BP_BTB_BITS;
  // Tests take about 50 cycles, the limit leaves a wide margin
  localparam int MaxCycles = 400;

  // Instruction encodings used as stimulus
  localparam logic [31:0] Nop     = 32'h0000_0013;
  localparam logic [31:0] Beq     = 32'h0000_0063;
  localparam logic [31:0] JalRa   = 32'h0000_00EF;
  localparam logic [31:0] JalZero = 32'h0000_006F;
  localparam logic [31:0] JalrRet = 32'h0000_8067;

  logic             clk;
  logic             arstN;
  stageCtrlT        ctrlF;
  stageCtrlT        ctrlD;
  stageCtrlT        ctrlE;
  stageCtrlT        ctrlM;
  logic [`XLEN-1:0] PCNextF;
  logic [`XLEN-1:0] PCF;
  logic [`XLEN-1:0] PCD;
  logic [`XLEN-1:0] PCPlus4F;
  logic [31:0]      InstrD;
  logic             BranchD;
  logic             JumpD;
  logic             InstrValidD;
  logic             InstrValidE;
  resolveT          resolveE;
  logic [`XLEN-1:0] PCNext1F;
  logic             BPPredWrongE;
  bpReportT         reportM;
  instrClassT       InstrClassM;
  logic             JumpOrTakenBranchM;

  // Reference copy of the predictor state
  logic [1:0]              mDir [DirEntries];
  logic                    mValid [BtbEntries];
  logic [`BP_TAG_BITS-1:0] mTag [BtbEntries];
  logic [`XLEN-1:0]        mTarget [BtbEntries];
  instrClassT              mCls [BtbEntries];
  logic [`XLEN-1:0]        mRas [$];

  int               cycles = 0;
  logic [`XLEN-1:0] addrA;
  logic [`XLEN-1:0] targetA;

  bpred i_bpred (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      stopOnError($sformatf("Timeout, the run went past %0d cycles", MaxCycles));
    end
  end

  //////////////////////////////////////////////////
  // Reporting and compare tasks
  //////////////////////////////////////////////////

  task automatic stopOnError(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic checkAddr(input string name, input logic [`XLEN-1:0] expVal,
                           input logic [`XLEN-1:0] actVal);
    if (actVal !== expVal) begin
      stopOnError($sformatf("ERR %0t %s expected %h actual %h", $time, name, expVal, actVal));
    end
  endtask

  task automatic checkReport(input string name, input bpReportT expVal, input bpReportT actVal);
    if (actVal !== expVal) begin
      stopOnError($sformatf("ERR %0t %s expected %b actual %b", $time, name, expVal, actVal));
    end
  endtask

  task automatic checkClass(input string name, input instrClassT expVal,
                            input instrClassT actVal);
    if (actVal !== expVal) begin
      stopOnError($sformatf("ERR %0t %s expected %b actual %b", $time, name, expVal, actVal));
    end
  endtask

  task automatic checkFlag(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      stopOnError($sformatf("ERR %0t %s expected %b actual %b", $time, name, expVal, actVal));
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic [`BP_DIR_BITS-1:0] dirSlot(input logic [`XLEN-1:0] pc);
    logic [`XLEN-3:0] full;
    full = pcIndex(pc);
    return full[`BP_DIR_BITS-1:0];
  endfunction

  function automatic logic [`BP_BTB_BITS-1:0] btbSlot(input logic [`XLEN-1:0] pc);
    logic [`XLEN-3:0] full;
    full = pcIndex(pc);
    return full[`BP_BTB_BITS-1:0];
  endfunction

  // Tag sits right above the BTB index
  function automatic logic [`BP_TAG_BITS-1:0] btbTagOf(input logic [`XLEN-1:0] pc);
    logic [`XLEN-3:0] full;
    full = pcIndex(pc);
    return full[`BP_BTB_BITS +: `BP_TAG_BITS];
  endfunction

  function automatic logic [`XLEN-1:0] rasTop();
    return (mRas.size() == 0) ? '0 : mRas[$];
  endfunction

  // True class from the core flags and the rd/rs1 link registers
  function automatic instrClassT decodeClass(input logic [31:0] instr, input logic br,
                                             input logic jp);
    instrClassT c;
    logic       isJalr;
    isJalr   = instr[6:0] == 7'b1100111;
    c.branch = br;
    c.jump   = jp;
    c.ret    = jp & isJalr & ((instr[19:15] == 5'd1) | (instr[19:15] == 5'd5));
    c.call   = jp & ((instr[11:7] == 5'd1) | (instr[11:7] == 5'd5));
    return c;
  endfunction

  // Fetch-side prediction for pc, pops the model RAS on a predicted return
  task automatic modelFetch(input logic [`XLEN-1:0] pc, output instrClassT cls,
                            output logic [1:0] dir, output logic [`XLEN-1:0] btbPc,
                            output logic [`XLEN-1:0] rasPc, output logic [`XLEN-1:0] nextPc);
    logic                    hit;
    logic [`BP_BTB_BITS-1:0] b;
    b     = btbSlot(pc);
    hit   = mValid[b] && (mTag[b] == btbTagOf(pc));
    cls   = hit ? mCls[b] : '0;
    btbPc = hit ? mTarget[b] : '0;
    dir   = mDir[dirSlot(pc)];
    rasPc = rasTop();
    if (cls.jump || (cls.branch && dir[1])) begin
      nextPc = cls.ret ? rasPc : btbPc;
    end else begin
      nextPc = pc + 4;
    end
    if (cls.ret && mRas.size() > 0) begin
      void'(mRas.pop_back());
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Empty pipeline, fetch parked at address 0 which never hits
  task automatic driveIdle();
    ctrlF       = '0;
    ctrlD       = '0;
    ctrlE       = '0;
    ctrlM       = '0;
    PCNextF     = '0;
    PCF         = '0;
    PCD         = '0;
    PCPlus4F    = 32'd4;
    InstrD      = Nop;
    BranchD     = 1'b0;
    JumpD       = 1'b0;
    InstrValidD = 1'b0;
    InstrValidE = 1'b0;
    resolveE    = '0;
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  // Fetch pc alone and check the next-fetch choice
  task automatic fetchCheck(input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] expNext);
    instrClassT       cls;
    logic [1:0]       dir;
    logic [`XLEN-1:0] btbPc;
    logic [`XLEN-1:0] rasPc;
    logic [`XLEN-1:0] modelNext;
    driveIdle();
    PCNextF = pc;
    nextCycle();
    driveIdle();
    PCF      = pc;
    PCPlus4F = pc + 4;
    modelFetch(pc, cls, dir, btbPc, rasPc, modelNext);
    if (modelNext !== expNext) begin
      stopOnError("Reference model and directed expectation disagree on the next fetch");
    end
    #1;
    checkAddr("PCNext1F", expNext, PCNext1F);
    nextCycle();
    driveIdle();
  endtask

  // One instruction from next-fetch through memory, checked every stage
  task automatic runFlow(input logic [`XLEN-1:0] pc, input logic [31:0] instr,
                         input logic br, input logic jp, input logic taken,
                         input logic [`XLEN-1:0] target,
                         output bpReportT rep, output instrClassT cls);
    instrClassT              predCls;
    instrClassT              decCls;
    logic [1:0]              dir;
    logic [`XLEN-1:0]        btbPc;
    logic [`XLEN-1:0]        rasPc;
    logic [`XLEN-1:0]        predNext;
    logic [`XLEN-1:0]        correct;
    logic                    wrong;
    logic                    jumpOrTaken;
    logic [`BP_BTB_BITS-1:0] b;
    logic [`BP_DIR_BITS-1:0] d;
    // Tables read with pc
    driveIdle();
    PCNextF = pc;
    nextCycle();
    // Fetch
    driveIdle();
    PCF      = pc;
    PCPlus4F = pc + 4;
    modelFetch(pc, predCls, dir, btbPc, rasPc, predNext);
    #1;
    checkAddr("PCNext1F", predNext, PCNext1F);
    nextCycle();
    // Decode
    driveIdle();
    PCD         = pc;
    InstrD      = instr;
    BranchD     = br;
    JumpD       = jp;
    InstrValidD = 1'b1;
    decCls      = decodeClass(instr, br, jp);
    #1;
    // Execute is empty, so nothing may correct the fetch yet
    checkFlag("BPPredWrongE", 1'b0, BPPredWrongE);
    checkAddr("PCNext1F", 32'd4, PCNext1F);
    nextCycle();
    // Execute, the predicted successor sits in decode
    driveIdle();
    PCD         = predNext;
    InstrValidD = 1'b1;
    InstrValidE = 1'b1;
    resolveE    = '{taken: taken, target: target, link: pc + 4, pc: pc};
    correct     = taken ? target : pc + 4;
    wrong       = correct != predNext;
    rep.predWrong  = wrong;
    rep.dirWrong   = decCls.branch && (dir[1] != taken);
    rep.btbWrong   = ((decCls.branch && taken) || (decCls.jump && !decCls.ret)) &&
                     (btbPc != target);
    rep.rasWrong   = decCls.ret && (rasPc != target);
    rep.classWrong = predCls != decCls;
    jumpOrTaken    = (decCls.branch && taken) || decCls.jump;
    cls            = decCls;
    #1;
    checkFlag("BPPredWrongE", wrong, BPPredWrongE);
    // Idle fetch at 0 falls through to 4
    checkAddr("PCNext1F", wrong ? correct : 32'd4, PCNext1F);
    nextCycle();
    // Model trains at the same edge as the DUT
    if (decCls.branch) begin
      d = dirSlot(pc);
      if (taken && mDir[d] != 2'b11) begin
        mDir[d] = mDir[d] + 2'd1;
      end else if (!taken && mDir[d] != 2'b00) begin
        mDir[d] = mDir[d] - 2'd1;
      end
    end
    if (rep.classWrong || rep.btbWrong) begin
      b          = btbSlot(pc);
      mValid[b]  = decCls != '0;
      mTag[b]    = btbTagOf(pc);
      mTarget[b] = target;
      mCls[b]    = decCls;
    end
    if (decCls.call) begin
      mRas.push_back(pc + 4);
      if (mRas.size() > `BP_RAS_DEPTH) begin
        void'(mRas.pop_front());
      end
    end
    // Memory, outputs settled at the edge
    driveIdle();
    checkReport("reportM", rep, reportM);
    checkClass("InstrClassM", decCls, InstrClassM);
    checkFlag("JumpOrTakenBranchM", jumpOrTaken, JumpOrTakenBranchM);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic resetIdle();
    fetchCheck(addrA, addrA + 4);
    checkReport("reportM", '0, reportM);
    checkClass("InstrClassM", '0, InstrClassM);
    checkFlag("JumpOrTakenBranchM", 1'b0, JumpOrTakenBranchM);
  endtask

  // First resolve trains counter to 10 and fills the BTB
  task automatic takenBranch();
    bpReportT   rep;
    instrClassT cls;
    runFlow(addrA, Beq, 1'b1, 1'b0, 1'b1, targetA, rep, cls);
    fetchCheck(addrA, targetA);
  endtask

  // Predicted taken, so decode holds the target
  task automatic notTakenBranch();
    bpReportT   rep;
    instrClassT cls;
    runFlow(addrA, Beq, 1'b1, 1'b0, 1'b0, targetA, rep, cls);
    // Counter back at 01, the fall-through is now predicted right
    runFlow(addrA, Beq, 1'b1, 1'b0, 1'b0, targetA, rep, cls);
  endtask

  task automatic callReturn();
    bpReportT         rep;
    instrClassT       cls;
    logic [`XLEN-1:0] callPc;
    logic [`XLEN-1:0] retPc;
    callPc = 32'h0000_1048;
    retPc  = 32'h0000_2154;
    runFlow(callPc, JalRa, 1'b0, 1'b1, 1'b1, 32'h0000_2100, rep, cls);
    // Return trained into the BTB, RAS still holds the link
    runFlow(retPc, JalrRet, 1'b0, 1'b1, 1'b1, callPc + 4, rep, cls);
    // Fetch predicts the link, execute resolves elsewhere
    runFlow(retPc, JalrRet, 1'b0, 1'b1, 1'b1, 32'h0000_5000, rep, cls);
  endtask

  task automatic classChange();
    bpReportT         rep;
    instrClassT       cls;
    logic [`XLEN-1:0] jumpPc;
    jumpPc = 32'h0000_30C8;
    runFlow(jumpPc, JalZero, 1'b0, 1'b1, 1'b1, 32'h0000_4400, rep, cls);
    // Same address now decodes as a plain instruction
    runFlow(jumpPc, Nop, 1'b0, 1'b0, 1'b0, '0, rep, cls);
    fetchCheck(jumpPc, jumpPc + 4);
  endtask

  task automatic memHold();
    bpReportT   rep;
    instrClassT cls;
    runFlow(addrA, Beq, 1'b1, 1'b0, 1'b1, targetA, rep, cls);
    ctrlM.stall = 1'b1;
    nextCycle();
    checkReport("reportM", rep, reportM);
    checkClass("InstrClassM", cls, InstrClassM);
    // Flush beats the stall
    ctrlM = '{stall: 1'b1, flush: 1'b1};
    nextCycle();
    checkReport("reportM", '0, reportM);
    checkClass("InstrClassM", '0, InstrClassM);
    checkFlag("JumpOrTakenBranchM", 1'b0, JumpOrTakenBranchM);
    driveIdle();
  endtask

  initial begin
    void'($urandom(27327));
    driveIdle();
    arstN = 1'b0;
    for (int i = 0; i < DirEntries; i++) begin
      mDir[i] = 2'b01;
    end
    for (int i = 0; i < BtbEntries; i++) begin
      mValid[i]  = 1'b0;
      mTag[i]    = '0;
      mTarget[i] = '0;
      mCls[i]    = '0;
    end
    // Bit 6 set keeps the tag nonzero, so the idle address never hits
    addrA   = 32'h1000_0040 | ($urandom() & 32'h0000_3FBC);
    targetA = addrA + 32'h0000_0200;
    repeat (4) @(posedge clk);
    #1;
    arstN = 1'b1;
    nextCycle();
    resetIdle();
    takenBranch();
    notTakenBranch();
    callReturn();
    classChange();
    memHold();
    $display("Regression passed");
    $finish;
  end

endmodule

//--- flist.f
+incdir+include
verilog/bpred_pkg.sv
verilog/bpClassDecode.sv
verilog/bpDirTable.sv
verilog/bpBtb.sv
verilog/bpRas.sv
verilog/bpResolve.sv
verilog/bpred.sv
dv/bpredTb.sv

//--- include/bpred_defines.svh
/*
  Branch predictor sizing
  Address width and the sizes of the counter table, BTB and RAS
*/
`ifndef BPRED_DEFINES_SVH
`define BPRED_DEFINES_SVH

// Address and PC width
`define XLEN 32

// Direction table index width, 64 two-bit counters
`define BP_DIR_BITS 6

// BTB index width, 16 entries
`define BP_BTB_BITS 4

// Partial tag kept per BTB entry
`define BP_TAG_BITS 8

// Return address stack entries
`define BP_RAS_DEPTH 4

`endif

//--- verilog/bpBtb.sv
/*
  Branch target buffer
  Tagged table of targets and instruction classes, read with the next
  fetch address, hit-checked against PCF and written from execute
*/
`include "bpred_defines.svh"

module bpBtb (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  stallF,
  input  logic [`XLEN-1:0]      PCNextF,
  input  logic [`XLEN-1:0]      PCF,
  output logic [`XLEN-1:0]      predPcF,
  output bpred_pkg::instrClassT predClassF,
  input  logic                  writeE,
  input  logic [`XLEN-1:0]      pcE,
  input  logic [`XLEN-1:0]      targetE,
  input  bpred_pkg::instrClassT classE
);
  import bpred_pkg::*;

  localparam int NumEntries = 2 ** `BP_BTB_BITS;

  // Stored payload of one entry
  typedef struct packed {
    logic [`BP_TAG_BITS-1:0] tag;
    logic [`XLEN-1:0]        target;
    instrClassT              cls;
  } btbEntryT;

  logic                    valid [NumEntries];
  btbEntryT                entries [NumEntries];
  logic                    rdValid;
  btbEntryT                rdEntry;
  logic [`XLEN-3:0]        rdFull;
  logic [`XLEN-3:0]        wrFull;
  logic [`XLEN-3:0]        fFull;
  logic [`BP_BTB_BITS-1:0] rdIdx;
  logic [`BP_BTB_BITS-1:0] wrIdx;
  logic                    hitF;

  assign rdFull = pcIndex(PCNextF);
  assign wrFull = pcIndex(pcE);
  assign fFull  = pcIndex(PCF);
  assign rdIdx  = rdFull[`BP_BTB_BITS-1:0];
  assign wrIdx  = wrFull[`BP_BTB_BITS-1:0];

  //////////////////////////////////////////////////
  // Storage and execute-stage write
  //////////////////////////////////////////////////

  // A resolved non-CFI (class zero) drops the entry
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < NumEntries; i++) begin
        valid[i] <= 1'b0;
      end
    end else if (writeE) begin
      valid[wrIdx] <= classE != '0;
    end
  end

  always_ff @(posedge clk) begin
    if (writeE) begin
      entries[wrIdx] <= '{tag: wrFull[`BP_BTB_BITS +: `BP_TAG_BITS],
                          target: targetE, cls: classE};
    end
  end

  //////////////////////////////////////////////////
  // Fetch-side read
  //////////////////////////////////////////////////

  // Valid bit is control state, the entry copy is payload
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rdValid <= 1'b0;
    end else if (!stallF) begin
      rdValid <= valid[rdIdx];
    end
  end

  always_ff @(posedge clk) begin
    if (!stallF) begin
      rdEntry <= entries[rdIdx];
    end
  end

  // Tag compare against the address now in fetch
  assign hitF = rdValid & (rdEntry.tag == fFull[`BP_BTB_BITS +: `BP_TAG_BITS]);

  // Miss looks like a plain instruction
  assign predPcF    = hitF ? rdEntry.target : '0;
  assign predClassF = hitF ? rdEntry.cls : '0;

  aWriteClassLegal : assert property (@(posedge clk) disable iff (!arstN)
    writeE |-> !(classE.branch && classE.jump));

endmodule

//--- verilog/bpClassDecode.sv
/*
  Instruction class decoder
  Rebuilds the true control-flow class of the decode-stage instruction
  from the core's branch/jump flags and the register fields
*/
`include "bpred_defines.svh"

module bpClassDecode (
  input  logic [31:0]           InstrD,
  input  logic                  BranchD,
  input  logic                  JumpD,
  output bpred_pkg::instrClassT classD
);

  // JALR major opcode
  localparam logic [6:0] OpJalr = 7'b1100111;

  logic [4:0] rd;
  logic [4:0] rs1;
  logic       isJalr;
  logic       rdLink;
  logic       rs1Link;

  // Register fields of the I/J formats
  assign rd  = InstrD[11:7];
  assign rs1 = InstrD[19:15];

  // JAL has no rs1, those bits are immediate
  assign isJalr = InstrD[6:0] == OpJalr;

  // Link registers per the calling convention, ra and t0
  assign rdLink  = (rd == 5'd1) | (rd == 5'd5);
  assign rs1Link = (rs1 == 5'd1) | (rs1 == 5'd5);

  // Branch and jump come straight from the main decoder
  assign classD.branch = BranchD;
  assign classD.jump   = JumpD;

  // Return jumps through a link register
  assign classD.ret = JumpD & isJalr & rs1Link;

  // Call writes a link register, JAL or JALR
  assign classD.call = JumpD & rdLink;

endmodule

//--- verilog/bpDirTable.sv
/*
  Branch direction table
  Two-bit saturating counters indexed by PC, read for the next fetch
  address and trained with the execute-stage outcome
*/
`include "bpred_defines.svh"

module bpDirTable (
  input  logic             clk,
  input  logic             arstN,
  input  logic             stallF,
  input  logic [`XLEN-1:0] PCNextF,
  output logic [1:0]       dirPredF,
  input  logic             updateE,
  input  logic [`XLEN-1:0] pcE,
  input  logic             takenE
);
  import bpred_pkg::*;

  localparam int NumEntries = 2 ** `BP_DIR_BITS;

  logic [1:0]              counters [NumEntries];
  logic [`XLEN-3:0]        rdFull;
  logic [`XLEN-3:0]        wrFull;
  logic [`BP_DIR_BITS-1:0] rdIdx;
  logic [`BP_DIR_BITS-1:0] wrIdx;
  logic [1:0]              wrOld;
  logic [1:0]              wrNext;

  assign rdFull = pcIndex(PCNextF);
  assign wrFull = pcIndex(pcE);
  assign rdIdx  = rdFull[`BP_DIR_BITS-1:0];
  assign wrIdx  = wrFull[`BP_DIR_BITS-1:0];
  assign wrOld  = counters[wrIdx];

  // Saturating step toward the outcome
  always_comb begin
    wrNext = wrOld;
    if (takenE && wrOld != 2'b11) begin
      wrNext = wrOld + 2'd1;
    end else if (!takenE && wrOld != 2'b00) begin
      wrNext = wrOld - 2'd1;
    end
  end

  // Counters start weakly not taken
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < NumEntries; i++) begin
        counters[i] <= 2'b01;
      end
    end else if (updateE) begin
      counters[wrIdx] <= wrNext;
    end
  end

  // Read register, its data belongs to PCF next cycle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      dirPredF <= 2'b01;
    end else if (!stallF) begin
      dirPredF <= counters[rdIdx];
    end
  end

  // Training strobes come from execute, never while the core is in reset
  aUpdateOutOfReset : assert property (@(posedge clk) !arstN |-> !updateE);

endmodule

//--- verilog/bpRas.sv
/*
  Return address stack
  Circular stack of link addresses, popped by a predicted return in
  fetch and pushed by a resolved call in execute
*/
`include "bpred_defines.svh"

module bpRas (
  input  logic             clk,
  input  logic             arstN,
  input  logic             popF,
  output logic [`XLEN-1:0] rasPcF,
  input  logic             pushE,
  input  logic [`XLEN-1:0] linkE
);

  localparam int PtrBits = $clog2(`BP_RAS_DEPTH);
  localparam logic [PtrBits:0] Full = `BP_RAS_DEPTH;

  logic [`XLEN-1:0]   stack [`BP_RAS_DEPTH];
  logic [PtrBits-1:0] top;
  logic [PtrBits-1:0] topInc;
  logic [PtrBits-1:0] topDec;
  logic [PtrBits:0]   count;

  // Pointer wraps, so a push on a full stack lands on the oldest entry
  assign topInc = top + 1'b1;
  assign topDec = top - 1'b1;

  // Empty stack predicts zero
  assign rasPcF = (count == '0) ? '0 : stack[top];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `BP_RAS_DEPTH; i++) begin
        stack[i] <= '0;
      end
      top   <= '0;
      count <= '0;
    end else begin
      case ({pushE, popF})
        // Pop and push together, the link replaces the top
        2'b11: begin
          stack[top] <= linkE;
          if (count == '0) begin
            count <= 1;
          end
        end
        2'b10: begin
          stack[topInc] <= linkE;
          top           <= topInc;
          if (count != Full) begin
            count <= count + 1'b1;
          end
        end
        // Pop of an empty stack leaves it empty
        2'b01: begin
          if (count != '0) begin
            top   <= topDec;
            count <= count - 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

//--- verilog/bpResolve.sv
/*
  Branch resolve
  Selects the next fetch address, carries each prediction down to
  execute, detects mispredicts per cause, trains the predictors and
  reports the outcome in memory
*/
`include "bpred_defines.svh"

module bpResolve (
  input  logic                  clk,
  input  logic                  arstN,
  input  bpred_pkg::stageCtrlT  ctrlF,
  input  bpred_pkg::stageCtrlT  ctrlD,
  input  bpred_pkg::stageCtrlT  ctrlE,
  input  bpred_pkg::stageCtrlT  ctrlM,
  input  logic [`XLEN-1:0]      PCPlus4F,
  input  logic [`XLEN-1:0]      PCD,
  input  logic [1:0]            dirPredF,
  input  logic [`XLEN-1:0]      predPcF,
  input  bpred_pkg::instrClassT predClassF,
  input  logic [`XLEN-1:0]      rasPcF,
  input  bpred_pkg::instrClassT classD,
  input  logic                  InstrValidD,
  input  logic                  InstrValidE,
  input  bpred_pkg::resolveT    resolveE,
  output logic                  dirUpdateE,
  output logic                  btbWriteE,
  output bpred_pkg::instrClassT classE,
  output logic                  rasPopF,
  output logic                  rasPushE,
  output logic [`XLEN-1:0]      PCNext1F,
  output logic                  BPPredWrongE,
  output bpred_pkg::bpReportT   reportM,
  output bpred_pkg::instrClassT InstrClassM,
  output logic                  JumpOrTakenBranchM
);
  import bpred_pkg::*;

  // Everything fetch predicted about one instruction
  typedef struct packed {
    instrClassT       cls;
    logic [1:0]       dir;
    logic [`XLEN-1:0] btbPc;
    logic [`XLEN-1:0] rasPc;
  } predT;

  // Execute stage register
  typedef struct packed {
    predT       pred;
    instrClassT cls;
    logic       classWrong;
  } exStageT;

  // Memory stage register
  typedef struct packed {
    bpReportT   report;
    instrClassT cls;
    logic       jumpOrTaken;
  } memStageT;

  predT             predF;
  predT             predD;
  exStageT          exD;
  exStageT          exE;
  memStageT         memE;
  memStageT         memM;
  logic             selPredF;
  logic [`XLEN-1:0] predTargetF;
  logic [`XLEN-1:0] next0F;
  logic [`XLEN-1:0] correctE;
  logic             writeOkE;

  //////////////////////////////////////////////////
  // Fetch: next PC
  //////////////////////////////////////////////////

  assign predF = '{cls: predClassF, dir: dirPredF, btbPc: predPcF, rasPc: rasPcF};

  // Jumps always redirect, branches only on a taken counter
  assign selPredF    = predClassF.jump | (predClassF.branch & dirPredF[1]);
  assign predTargetF = predClassF.ret ? rasPcF : predPcF;
  assign next0F      = selPredF ? predTargetF : PCPlus4F;

  // Execute correction overrides the fetch choice
  assign correctE     = resolveE.taken ? resolveE.target : resolveE.link;
  assign BPPredWrongE = (correctE != PCD) & InstrValidD & InstrValidE;
  assign PCNext1F     = BPPredWrongE ? correctE : next0F;

  //////////////////////////////////////////////////
  // Prediction pipeline
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      predD <= '0;
    end else if (ctrlD.flush) begin
      predD <= '0;
    end else if (!ctrlD.stall) begin
      predD <= predF;
    end
  end

  // Class check happens in decode against the rebuilt class
  assign exD.pred       = predD;
  assign exD.cls        = classD;
  assign exD.classWrong = (predD.cls != classD) & InstrValidD;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exE <= '0;
    end else if (ctrlE.flush) begin
      exE <= '0;
    end else if (!ctrlE.stall) begin
      exE <= exD;
    end
  end

  // Bubbles carry no class
  assign classE = InstrValidE ? exE.cls : '0;

  //////////////////////////////////////////////////
  // Execute: mispredict causes and training
  //////////////////////////////////////////////////

  assign memE.report.predWrong  = BPPredWrongE;
  assign memE.report.dirWrong   = classE.branch & (exE.pred.dir[1] != resolveE.taken);
  assign memE.report.btbWrong   = ((classE.branch & resolveE.taken) |
                                   (classE.jump & ~classE.ret)) &
                                  (exE.pred.btbPc != resolveE.target);
  assign memE.report.rasWrong   = classE.ret & (exE.pred.rasPc != resolveE.target);
  assign memE.report.classWrong = exE.classWrong & InstrValidE;
  assign memE.cls               = classE;
  assign memE.jumpOrTaken       = (classE.branch & resolveE.taken) | classE.jump;

  // A held execute stage would train twice
  assign writeOkE = ~ctrlE.stall;

  assign dirUpdateE = classE.branch & writeOkE;
  assign btbWriteE  = (memE.report.classWrong | memE.report.btbWrong) & writeOkE;
  assign rasPushE   = classE.call & writeOkE;

  // Pop once per fetched return
  assign rasPopF = predClassF.ret & ~ctrlF.stall;

  //////////////////////////////////////////////////
  // Memory: report
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memM <= '0;
    end else if (ctrlM.flush) begin
      memM <= '0;
    end else if (!ctrlM.stall) begin
      memM <= memE;
    end
  end

  assign reportM            = memM.report;
  assign InstrClassM        = memM.cls;
  assign JumpOrTakenBranchM = memM.jumpOrTaken;

  // Decoder and core flags must never mark one instruction as both
  aClassExclusiveE : assert property (@(posedge clk) disable iff (!arstN)
    !(classE.branch && classE.jump));

endmodule

//--- verilog/bpred.sv
/*
  Branch predictor top level
  Class decoder, direction table, BTB and RAS feeding the resolve block
*/
`include "bpred_defines.svh"

module bpred (
  input  logic                  clk,
  input  logic                  arstN,
  input  bpred_pkg::stageCtrlT  ctrlF,
  input  bpred_pkg::stageCtrlT  ctrlD,
  input  bpred_pkg::stageCtrlT  ctrlE,
  input  bpred_pkg::stageCtrlT  ctrlM,
  input  logic [`XLEN-1:0]      PCNextF,
  input  logic [`XLEN-1:0]      PCF,
  input  logic [`XLEN-1:0]      PCD,
  input  logic [`XLEN-1:0]      PCPlus4F,
  input  logic [31:0]           InstrD,
  input  logic                  BranchD,
  input  logic                  JumpD,
  input  logic                  InstrValidD,
  input  logic                  InstrValidE,
  input  bpred_pkg::resolveT    resolveE,
  output logic [`XLEN-1:0]      PCNext1F,
  output logic                  BPPredWrongE,
  output bpred_pkg::bpReportT   reportM,
  output bpred_pkg::instrClassT InstrClassM,
  output logic                  JumpOrTakenBranchM
);
  import bpred_pkg::*;

  logic [1:0]       dirPredF;
  logic [`XLEN-1:0] predPcF;
  logic [`XLEN-1:0] rasPcF;
  instrClassT       predClassF;
  instrClassT       classD;
  instrClassT       classE;
  logic             dirUpdateE;
  logic             btbWriteE;
  logic             rasPopF;
  logic             rasPushE;

  // Input side
  bpClassDecode i_bpClassDecode (.InstrD, .BranchD, .JumpD, .classD);

  // Predictors
  bpDirTable i_bpDirTable (
    .clk, .arstN, .stallF(ctrlF.stall), .PCNextF, .dirPredF,
    .updateE(dirUpdateE), .pcE(resolveE.pc), .takenE(resolveE.taken)
  );

  bpBtb i_bpBtb (
    .clk, .arstN, .stallF(ctrlF.stall), .PCNextF, .PCF, .predPcF, .predClassF,
    .writeE(btbWriteE), .pcE(resolveE.pc), .targetE(resolveE.target), .classE
  );

  bpRas i_bpRas (
    .clk, .arstN, .popF(rasPopF), .rasPcF, .pushE(rasPushE), .linkE(resolveE.link)
  );

  // Output side
  bpResolve i_bpResolve (
    .clk, .arstN, .ctrlF, .ctrlD, .ctrlE, .ctrlM, .PCPlus4F, .PCD,
    .dirPredF, .predPcF, .predClassF, .rasPcF, .classD,
    .InstrValidD, .InstrValidE, .resolveE,
    .dirUpdateE, .btbWriteE, .classE, .rasPopF, .rasPushE,
    .PCNext1F, .BPPredWrongE, .reportM, .InstrClassM, .JumpOrTakenBranchM
  );

endmodule

//--- verilog/bpred_pkg.sv
/*
  Branch predictor shared types
  Instruction class vector, per-stage stall/flush, execute outcome,
  memory-stage mispredict report and the PC-to-index helper
*/
`include "bpred_defines.svh"

package bpred_pkg;

  // Control-flow class, bit 0 is branch and bit 3 is call
  typedef struct packed {
    logic call;
    logic ret;
    logic jump;
    logic branch;
  } instrClassT;

  // Stall and flush of one pipeline stage
  // Flush wins over stall
  typedef struct packed {
    logic stall;
    logic flush;
  } stageCtrlT;

  // Execute-stage outcome of a control-flow instruction
  typedef struct packed {
    logic             taken;   // PCSrcE
    logic [`XLEN-1:0] target;  // IEUAdrE
    logic [`XLEN-1:0] link;    // PCLinkE, fall-through address
    logic [`XLEN-1:0] pc;      // PCE
  } resolveT;

  // Mispredict causes seen in memory
  typedef struct packed {
    logic predWrong;
    logic dirWrong;
    logic btbWrong;
    logic rasWrong;
    logic classWrong;
  } bpReportT;

  // PCs step by four, so index bits start at bit 2
  // Callers slice the low bits for the index and the next ones for a tag
  function automatic logic [`XLEN-3:0] pcIndex(input logic [`XLEN-1:0] pc);
    return pc[`XLEN-1:2];
  endfunction

endpackage
